// File: rtl/ddr_sched_defines.svh
`ifndef DDR_SCHED_DEFINES_SVH
`define DDR_SCHED_DEFINES_SVH

// ---------------------------------------------------------------------------
// field widths
// ---------------------------------------------------------------------------
`define ADDR_W 26            // request word address
`define ROW_W 14             // also the command address bus
`define BANK_W 3
`define COL_W 9
`define MASK_W 4

// ---------------------------------------------------------------------------
// command spacing, in clock cycles from one command to the next
// ---------------------------------------------------------------------------
`define GAP_ACTV 2           // after ACTV
`define GAP_RDPR 3           // after READ or PRCH
`define GAP_WRTE 4           // after WRTE, write recovery included
`define GAP_ARSR 11          // after ARSR

`define T_RAS 5              // ACTV to PRCH minimum
`define PRCH_ADDR 14'h0400   // A10 high, precharge of the open row

`endif

// File: rtl/ddr_sched_pkg.sv
package ddr_sched_pkg;

  `include "ddr_sched_defines.svh"

  // SDRAM command pins, {ras_n, cas_n, we_n}
  typedef enum logic [2:0] {
    NOOP = 3'b111,
    ACTV = 3'b011,
    READ = 3'b101,
    WRTE = 3'b100,
    PRCH = 3'b010,
    ARSR = 3'b001
  } cmd_t;

  typedef logic [`ROW_W-1:0] row_t;
  typedef logic [`BANK_W-1:0] bank_t;
  typedef logic [`COL_W-1:0] col_t;
  typedef logic [`ROW_W+`BANK_W-1:0] page_t;   // {row, bank}
  typedef logic [`MASK_W-1:0] mask_t;
  typedef logic [`ROW_W-1:0] abus_t;

  typedef struct packed {
    row_t row;
    bank_t bank;
    col_t col;
  } req_fields_t;

  typedef struct packed {
    page_t page;
    col_t col;
  } req_page_t;

  // one request word, seen as fields or as page + column
  typedef union packed {
    req_fields_t f;
    req_page_t p;
  } req_addr_u;

endpackage

// File: rtl/ddr_sched_if.sv
`timescale 1ns/1ps

// state of the open page and the timers, execute to decode
interface sched_state_if;
  import ddr_sched_pkg::*;

  logic ready;                 // command gap elapsed
  logic page_open;
  page_t open_page;
  logic ras_done;              // T_RAS met since last ACTV
  logic refresh_pending;

  modport exec (
    output ready, page_open, open_page, ras_done, refresh_pending
  );

  modport dec (
    input ready, page_open, open_page, ras_done, refresh_pending
  );

endinterface

// the command chosen this cycle, decode to execute and result
interface issue_if;
  import ddr_sched_pkg::*;

  logic issue;                 // one cycle strobe
  cmd_t cmd;
  abus_t abus;
  bank_t bank;
  page_t page;

  modport dec (output issue, cmd, abus, bank, page);

  modport exec (input issue, cmd, page);

  modport res (input issue, cmd, abus, bank);

endinterface

// File: rtl/ddr_cmd_decode.sv
`timescale 1ns/1ps

`include "ddr_sched_defines.svh"

module ddr_cmd_decode (
  input logic INPUT_CLK,
  input logic RST,
  input logic request,
  input logic write,
  input ddr_sched_pkg::req_addr_u address,
  sched_state_if.dec st,
  issue_if.dec iss
);
  import ddr_sched_pkg::*;

  logic refresh_flag;          // refresh precharge done, ARSR still owed
  logic refresh_want;
  logic page_hit;
  logic go;
  cmd_t cmd_nxt;

  assign refresh_want = st.refresh_pending || refresh_flag;
  assign page_hit = st.page_open && (address.p.page == st.open_page);

  // ---------------------------------------------------------------------------
  // command priority: refresh, hit, miss close, open
  // ---------------------------------------------------------------------------
  always_comb
  begin
    cmd_nxt = NOOP;
    go = 1'b0;
    if (refresh_want)
    begin
      if (st.page_open)
      begin
        cmd_nxt = PRCH;
        go = st.ras_done;
      end
      else
      begin
        cmd_nxt = ARSR;
        go = 1'b1;
      end
    end
    else if (request)
    begin
      if (page_hit)
      begin
        cmd_nxt = write ? WRTE : READ;
        go = 1'b1;
      end
      else if (st.page_open)
      begin
        cmd_nxt = PRCH;        // close the wrong row first
        go = st.ras_done;
      end
      else
      begin
        cmd_nxt = ACTV;
        go = 1'b1;
      end
    end
  end

  always_comb
  begin
    case (cmd_nxt)
      ACTV: iss.abus = address.f.row;
      READ, WRTE: iss.abus = {{(`ROW_W-`COL_W-1){1'b0}}, address.f.col, 1'b0};
      PRCH: iss.abus = `PRCH_ADDR;
      default: iss.abus = '0;
    endcase
    case (cmd_nxt)
      PRCH: iss.bank = st.open_page[`BANK_W-1:0];   // bank of the open page
      ARSR: iss.bank = '0;
      default: iss.bank = address.f.bank;
    endcase
  end

  assign iss.issue = st.ready && go;
  assign iss.cmd = cmd_nxt;
  assign iss.page = address.p.page;

  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
      refresh_flag <= 1'b0;
    else if (st.ready && go)
    begin
      if (cmd_nxt == PRCH && refresh_want)
        refresh_flag <= 1'b1;
      else if (cmd_nxt == ARSR)
        refresh_flag <= 1'b0;
    end
  end

endmodule

// File: rtl/ddr_bank_execute.sv
`timescale 1ns/1ps

`include "ddr_sched_defines.svh"

module ddr_bank_execute (
  input logic INPUT_CLK,
  input logic RST,
  input logic refresh_strobe,
  sched_state_if.exec st,
  issue_if.exec iss
);
  import ddr_sched_pkg::*;

  localparam int GAP_W = $clog2(`GAP_ARSR + 1);
  localparam int RAS_W = $clog2(`T_RAS + 1);

  logic [GAP_W-1:0] gap_cnt;   // zero means the next command may go
  logic [RAS_W-1:0] ras_cnt;
  logic page_open;
  page_t open_page;
  logic refresh_ack;

  // ---------------------------------------------------------------------------
  // command gap and row active timers
  // ---------------------------------------------------------------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      gap_cnt <= '0;
      ras_cnt <= '0;
    end
    else
    begin
      if (iss.issue)
      begin
        case (iss.cmd)
          ACTV: gap_cnt <= GAP_W'(`GAP_ACTV - 1);
          READ, PRCH: gap_cnt <= GAP_W'(`GAP_RDPR - 1);
          WRTE: gap_cnt <= GAP_W'(`GAP_WRTE - 1);
          ARSR: gap_cnt <= GAP_W'(`GAP_ARSR - 1);
          default: gap_cnt <= '0;
        endcase
      end
      else if (gap_cnt != '0)
        gap_cnt <= gap_cnt - 1'b1;

      if (iss.issue && iss.cmd == ACTV)
        ras_cnt <= RAS_W'(`T_RAS - 1);   // restart on every row open
      else if (ras_cnt != '0)
        ras_cnt <= ras_cnt - 1'b1;
    end
  end

  // ---------------------------------------------------------------------------
  // open page and refresh handshake
  // ---------------------------------------------------------------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      page_open <= 1'b0;
      refresh_ack <= refresh_strobe;   // nothing pending out of reset
    end
    else if (iss.issue)
    begin
      if (iss.cmd == ACTV)
        page_open <= 1'b1;
      else if (iss.cmd == PRCH)
        page_open <= 1'b0;
      if (iss.cmd == ARSR)
        refresh_ack <= refresh_strobe;
    end
  end

  always_ff @(posedge INPUT_CLK)
  begin
    if (iss.issue && iss.cmd == ACTV)
      open_page <= iss.page;
  end

  assign st.ready = (gap_cnt == '0);
  assign st.ras_done = (ras_cnt == '0);
  assign st.page_open = page_open;
  assign st.open_page = open_page;
  assign st.refresh_pending = refresh_strobe ^ refresh_ack;

endmodule

// File: rtl/ddr_cmd_result.sv
`timescale 1ns/1ps

module ddr_cmd_result (
  input logic INPUT_CLK,
  input logic RST,
  issue_if.res iss,
  input ddr_sched_pkg::mask_t mask_in,
  output ddr_sched_pkg::cmd_t command,
  output ddr_sched_pkg::abus_t addr_out,
  output ddr_sched_pkg::bank_t bank,
  output logic grant,
  output ddr_sched_pkg::mask_t write_mask
);
  import ddr_sched_pkg::*;

  logic is_access;

  assign is_access = (iss.cmd == READ) || (iss.cmd == WRTE);

  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      command <= NOOP;
      grant <= 1'b0;
    end
    else
    begin
      command <= iss.issue ? iss.cmd : NOOP;
      grant <= iss.issue && is_access;   // same cycle as READ/WRTE
    end
  end

  // address and bank hold between commands
  always_ff @(posedge INPUT_CLK)
  begin
    if (iss.issue)
    begin
      addr_out <= iss.abus;
      bank <= iss.bank;
    end
    if (iss.issue && iss.cmd == WRTE)
      write_mask <= mask_in;
  end

endmodule

// File: rtl/ddr_sched_top.sv
`timescale 1ns/1ps

`include "ddr_sched_defines.svh"

module ddr_sched_top (
  input logic INPUT_CLK,
  input logic RST,
  input logic refresh_strobe,
  input logic request,
  input logic write,
  input logic [`ADDR_W-1:0] address,
  input ddr_sched_pkg::mask_t we_array,
  output logic grant,
  output ddr_sched_pkg::cmd_t command,
  output ddr_sched_pkg::abus_t addr_out,
  output ddr_sched_pkg::bank_t bank,
  output ddr_sched_pkg::mask_t write_mask
);

  sched_state_if st_if ();
  issue_if iss_if ();

  ddr_cmd_decode u_decode (
    .INPUT_CLK (INPUT_CLK),
    .RST       (RST),
    .request   (request),
    .write     (write),
    .address   (address),
    .st        (st_if.dec),
    .iss       (iss_if.dec)
  );

  ddr_bank_execute u_execute (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .refresh_strobe (refresh_strobe),
    .st             (st_if.exec),
    .iss            (iss_if.exec)
  );

  ddr_cmd_result u_result (
    .INPUT_CLK  (INPUT_CLK),
    .RST        (RST),
    .iss        (iss_if.res),
    .mask_in    (we_array),
    .command    (command),
    .addr_out   (addr_out),
    .bank       (bank),
    .grant      (grant),
    .write_mask (write_mask)
  );

endmodule

// File: test/ddr_sched_props.sv
`timescale 1ns/1ps

`include "ddr_sched_defines.svh"

module ddr_sched_props (
  input logic INPUT_CLK,
  input logic RST,
  input logic grant,
  input ddr_sched_pkg::cmd_t command,
  input ddr_sched_pkg::abus_t addr_out
);
  import ddr_sched_pkg::*;

  a_grant_access: assert property (
    @(posedge INPUT_CLK) disable iff (RST)
      grant |-> (command == READ || command == WRTE)
  ) else $error("grant without READ or WRTE");

  a_access_grant: assert property (
    @(posedge INPUT_CLK) disable iff (RST)
      (command == READ || command == WRTE) |-> grant
  ) else $error("READ or WRTE without grant");

  a_prch_addr: assert property (
    @(posedge INPUT_CLK) disable iff (RST)
      (command == PRCH) |-> (addr_out == `PRCH_ADDR)
  ) else $error("precharge without A10 set");

  // first cycle out of reset
  a_reset_noop: assert property (
    @(posedge INPUT_CLK) $fell(RST) |-> (command == NOOP)
  ) else $error("command not NOOP after reset");

endmodule

bind ddr_sched_top ddr_sched_props u_props (
  .INPUT_CLK (INPUT_CLK),
  .RST       (RST),
  .grant     (grant),
  .command   (command),
  .addr_out  (addr_out)
);

// File: test/ddr_sched_tb.sv
`timescale 1ns/1ps

`include "ddr_sched_defines.svh"

module ddr_sched_tb;
  import ddr_sched_pkg::*;

  localparam int TIMEOUT = 64;   // cycles allowed per wait

  logic INPUT_CLK;
  logic RST;
  logic refresh_strobe;
  logic request;
  logic write;
  logic [`ADDR_W-1:0] address;
  mask_t we_array;
  logic grant;
  cmd_t command;
  abus_t addr_out;
  bank_t bank;
  mask_t write_mask;

  int seed;
  int cyc = 0;
  int last_cyc = 0;
  int last_actv_cyc = -100;
  cmd_t last_cmd = NOOP;
  logic open_valid;              // model of the open page
  page_t open_page;

  ddr_sched_top DUT (.*);

  initial
  begin
    INPUT_CLK = 1'b0;
    forever
      #20 INPUT_CLK = ~INPUT_CLK;
  end

  always @(posedge INPUT_CLK)
    cyc <= cyc + 1;

  // --------------------------------------------------------------------------
  // failure reporting and typed compares
  // --------------------------------------------------------------------------
  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1, "stopped at the first failed check");
  endtask

  task automatic value_error(input string what);
    stop_run($sformatf("[ERROR] t=%0t %s", $time, what));
  endtask

  task automatic check_cmd(input cmd_t exp, input cmd_t got, input string what);
    if (got !== exp)
      value_error($sformatf("%s: expected %s, got %s", what, exp.name(), got.name()));
  endtask

  task automatic check_abus(input abus_t exp, input abus_t got, input string what);
    if (got !== exp)
      value_error($sformatf("%s: expected %h, got %h", what, exp, got));
  endtask

  task automatic check_bank(input bank_t exp, input bank_t got, input string what);
    if (got !== exp)
      value_error($sformatf("%s: expected %0d, got %0d", what, exp, got));
  endtask

  task automatic check_mask(input mask_t exp, input mask_t got, input string what);
    if (got !== exp)
      value_error($sformatf("%s: expected %b, got %b", what, exp, got));
  endtask

  task automatic check_flag(input logic exp, input logic got, input string what);
    if (got !== exp)
      value_error($sformatf("%s: expected %b, got %b", what, exp, got));
  endtask

  function automatic int gap_of(input cmd_t c);
    case (c)
      ACTV: return `GAP_ACTV;
      WRTE: return `GAP_WRTE;
      ARSR: return `GAP_ARSR;
      default: return `GAP_RDPR;   // READ and PRCH
    endcase
  endfunction

  // spacing monitor
  always @(negedge INPUT_CLK)
  begin
    if (!RST && command != NOOP)
    begin
      if (last_cmd != NOOP && cyc - last_cyc < gap_of(last_cmd))
        value_error($sformatf("%s only %0d cycles after %s",
                              command.name(), cyc - last_cyc, last_cmd.name()));
      if (command == PRCH && cyc - last_actv_cyc < `T_RAS)
        value_error($sformatf("PRCH only %0d cycles after ACTV", cyc - last_actv_cyc));
      if (command == ACTV)
        last_actv_cyc = cyc;
      last_cmd = command;
      last_cyc = cyc;
    end
  end

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------
  task automatic expect_quiet(input int n);
    repeat (n)
    begin
      @(negedge INPUT_CLK);
      check_cmd(NOOP, command, "idle command");
      check_flag(1'b0, grant, "idle grant");
    end
  endtask

  task automatic do_access(input logic [`ADDR_W-1:0] a, input logic wr, input mask_t m,
                           input logic with_refresh);
    req_addr_u ra;
    logic hit;
    bank_t old_bank;
    abus_t col_bus;
    cmd_t exp_q[$];
    cmd_t seen_q[$];
    int actv_cyc;
    int t;
    ra = a;
    hit = open_valid && (ra.p.page == open_page) && !with_refresh;
    old_bank = open_page[`BANK_W-1:0];
    col_bus = '0;
    col_bus[`COL_W:1] = ra.f.col;   // column above a zero bit
    actv_cyc = 0;
    if (open_valid && !hit)
      exp_q.push_back(PRCH);
    if (with_refresh)
      exp_q.push_back(ARSR);
    if (!hit)
      exp_q.push_back(ACTV);
    exp_q.push_back(wr ? WRTE : READ);
    @(negedge INPUT_CLK);
    request = 1'b1;
    write = wr;
    address = a;
    we_array = m;
    if (with_refresh)
      refresh_strobe = ~refresh_strobe;
    t = 0;
    while (grant !== 1'b1)
    begin
      @(negedge INPUT_CLK);
      t++;
      if (t > TIMEOUT)
        stop_run("timeout waiting for grant");
      if (command != NOOP)
        seen_q.push_back(command);
      case (command)
        PRCH:
        begin
          check_abus(`PRCH_ADDR, addr_out, "precharge address");
          check_bank(old_bank, bank, "precharge bank");
        end
        ARSR:
        begin
          check_abus('0, addr_out, "refresh address");
          check_bank('0, bank, "refresh bank");
        end
        ACTV:
        begin
          check_abus(ra.f.row, addr_out, "activate row");
          check_bank(ra.f.bank, bank, "activate bank");
          actv_cyc = cyc;
        end
        READ, WRTE:
        begin
          check_abus(col_bus, addr_out, "access column");
          check_bank(ra.f.bank, bank, "access bank");
        end
        default: ;
      endcase
    end
    request = 1'b0;
    if (seen_q.size() != exp_q.size())
      stop_run($sformatf("expected %0d commands up to the grant but saw %0d",
                         exp_q.size(), seen_q.size()));
    foreach (exp_q[i])
      check_cmd(exp_q[i], seen_q[i], "command order");
    if (!hit && cyc - actv_cyc != `GAP_ACTV)
      value_error($sformatf("access %0d cycles after ACTV", cyc - actv_cyc));
    if (wr)
      check_mask(m, write_mask, "write mask");
    open_valid = 1'b1;
    open_page = ra.p.page;
  endtask

  task automatic do_refresh();
    cmd_t exp_q[$];
    cmd_t seen_q[$];
    int t;
    if (open_valid)
      exp_q.push_back(PRCH);
    exp_q.push_back(ARSR);
    @(negedge INPUT_CLK);
    refresh_strobe = ~refresh_strobe;
    t = 0;
    while (seen_q.size() == 0 || seen_q[$] != ARSR)
    begin
      @(negedge INPUT_CLK);
      t++;
      if (t > TIMEOUT)
        stop_run("timeout waiting for the refresh command");
      if (command != NOOP)
        seen_q.push_back(command);
    end
    if (seen_q.size() != exp_q.size())
      stop_run($sformatf("expected %0d refresh commands but saw %0d",
                         exp_q.size(), seen_q.size()));
    foreach (exp_q[i])
      check_cmd(exp_q[i], seen_q[i], "refresh order");
    open_valid = 1'b0;
    expect_quiet(`GAP_ARSR + 4);     // one ARSR per toggle
  endtask

  // read to a closed bank, with a refresh toggle as soon as the row opens
  task automatic refresh_after_actv(input logic [`ADDR_W-1:0] a);
    cmd_t exp_q[$];
    cmd_t seen_q[$];
    int t;
    exp_q.push_back(ACTV);
    exp_q.push_back(PRCH);           // held back until T_RAS
    exp_q.push_back(ARSR);
    exp_q.push_back(ACTV);
    exp_q.push_back(READ);
    @(negedge INPUT_CLK);
    request = 1'b1;
    write = 1'b0;
    address = a;
    t = 0;
    while (grant !== 1'b1)
    begin
      @(negedge INPUT_CLK);
      t++;
      if (t > TIMEOUT)
        stop_run("timeout waiting for grant behind the refresh");
      if (command != NOOP)
        seen_q.push_back(command);
      if (command == ACTV && seen_q.size() == 1)
        refresh_strobe = ~refresh_strobe;   // row is still young
    end
    request = 1'b0;
    if (seen_q.size() != exp_q.size())
      stop_run($sformatf("expected %0d commands up to the grant but saw %0d",
                         exp_q.size(), seen_q.size()));
    foreach (exp_q[i])
      check_cmd(exp_q[i], seen_q[i], "refresh after ACTV order");
    open_valid = 1'b1;
    open_page = a[`ADDR_W-1:`COL_W];
  endtask

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------
  task automatic test_reset();
    check_cmd(NOOP, command, "command after reset");
    check_flag(1'b0, grant, "grant after reset");
    expect_quiet(8);
  endtask

  task automatic test_page_access();
    do_access({14'h1234, 3'd2, 9'h05a}, 1'b0, 4'h0, 1'b0);   // closed bank read
    do_access({14'h1234, 3'd2, 9'h101}, 1'b1, 4'b1010, 1'b0); // hit write
    do_access({14'h0777, 3'd5, 9'h033}, 1'b1, 4'b0110, 1'b0);
    do_access({14'h2abc, 3'd5, 9'h1f0}, 1'b0, 4'h0, 1'b0);   // miss right after open
  endtask

  task automatic test_refresh();
    do_refresh();
    do_refresh();
    refresh_after_actv({14'h0155, 3'd3, 9'h020});
    do_access({14'h0042, 3'd1, 9'h00f}, 1'b1, 4'b0011, 1'b1);
    do_access({14'h3001, 3'd6, 9'h0c4}, 1'b0, 4'h0, 1'b1);   // refresh with a page open
  endtask

  task automatic test_random();
    logic [31:0] r;
    logic [`ADDR_W-1:0] a;
    int i;
    for (i = 0; i < 20; i++)
    begin
      r = $random(seed);
      a = `ADDR_W'($random(seed));
      if (r[0] && open_valid)
        a[`ADDR_W-1:`COL_W] = open_page;   // stay on the open page
      do_access(a, r[1], r[5:2], 1'b0);
    end
  endtask

  initial
  begin
    seed = 32'hcc0d6329;
    RST = 1'b1;
    refresh_strobe = 1'b0;
    request = 1'b0;
    write = 1'b0;
    address = '0;
    we_array = '0;
    open_valid = 1'b0;
    open_page = '0;
    repeat (3)
      @(posedge INPUT_CLK);
    @(negedge INPUT_CLK);
    RST = 1'b0;
    test_reset();
    test_page_access();
    test_refresh();
    test_random();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: ddr_sched.f
+incdir+rtl
rtl/ddr_sched_pkg.sv
rtl/ddr_sched_if.sv
rtl/ddr_cmd_decode.sv
rtl/ddr_bank_execute.sv
rtl/ddr_cmd_result.sv
rtl/ddr_sched_top.sv
test/ddr_sched_props.sv
test/ddr_sched_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it, exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f ddr_sched.f \
  --top-module ddr_sched_tb -o ddr_sched_sim &&
./obj_dir/ddr_sched_sim ||
{ echo "build or run of ddr_sched_tb returned an error" >&2; exit 1; }
